//--- common/hpm_pkg.sv
// Performance monitor shared definitions
// Widths, value types and event indices
// APB register map offsets
// APB request/response and counter preload structs

package hpm_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int unsigned DATA_W       = 32;  // APB data and counter width
    localparam int unsigned APB_ADDR_W   = 8;
    localparam int unsigned MAX_COUNTERS = 8;   // Upper bound for NUM_COUNTERS
    localparam int unsigned CNT_IDX_W    = 3;
    localparam int unsigned NUM_EVENTS   = 8;
    localparam int unsigned EVT_SEL_W    = 3;

    typedef logic [DATA_W-1:0]     hpm_data_t;
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [EVT_SEL_W-1:0]  evt_sel_t;     // Event watched by a counter
    typedef logic [CNT_IDX_W-1:0]  cnt_idx_t;
    typedef logic [NUM_EVENTS-1:0] hpm_events_t;  // One bit per event

    // Event line positions, also the selector encoding
    typedef enum logic [EVT_SEL_W-1:0] {
        EVT_CYCLE         = 3'd0,
        EVT_IC_REQ        = 3'd1,
        EVT_IC_KILL       = 3'd2,
        EVT_IC_BUSY       = 3'd3,
        EVT_L2_HIT        = 3'd4,
        EVT_ITLB_MISS_CYC = 3'd5,
        EVT_LOAD          = 3'd6,
        EVT_STORE         = 3'd7
    } hpm_event_e;

    // ------------------------------
    // Register map
    // ------------------------------
    localparam apb_addr_t   REG_CTRL     = 8'h00;
    localparam apb_addr_t   REG_SEL_BASE = 8'h10;  // Selector n at base + 4n
    localparam apb_addr_t   REG_CNT_BASE = 8'h20;  // Counter n at base + 4n
    localparam int unsigned CTRL_EN_BIT  = 0;      // Global count enable

    // ------------------------------
    // Bus and strobe bundles
    // ------------------------------
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        hpm_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        logic      pready;
        logic      pslverr;
        hpm_data_t prdata;
    } apb_rsp_t;

    // Counter preload from the register side
    typedef struct packed {
        logic      valid;
        cnt_idx_t  idx;
        hpm_data_t data;
    } cnt_wr_t;

endpackage

//--- hpm/hpm_event_gen.sv
// Performance monitor event conditioning
// Derives the event vector from raw core signals
// and registers it once

`timescale 1ns/1ps

module hpm_event_gen
    import hpm_pkg::*;
(
    input  logic        CLK,
    input  logic        RST,

    // Instruction fetch side
    input  logic        icache_req_valid_i,
    input  logic        icache_req_kill_i,
    input  logic        icache_ready_i,

    // Refill grant from L2
    input  logic        grant_valid_i,
    input  logic [1:0]  grant_beat_i,
    input  logic        l2_hit_i,

    // Instruction TLB
    input  logic        itlb_miss_i,
    input  logic        itlb_ready_i,

    // Data memory
    input  logic        dmem_is_load_i,
    input  logic        dmem_is_store_i,

    output hpm_events_t events_o
);

    localparam logic [1:0] LAST_BEAT = 2'd3;  // Fourth beat closes a refill

    hpm_events_t events_d;
    hpm_events_t events_q;
    logic        refill_done;
    logic        l2_hit_evt;
    logic        itlb_miss_cyc;

    // ------------------------------
    // Derived conditions
    // ------------------------------
    assign refill_done   = grant_valid_i && (grant_beat_i == LAST_BEAT);
    assign l2_hit_evt    = refill_done && l2_hit_i;
    assign itlb_miss_cyc = itlb_miss_i && !itlb_ready_i;  // Waiting on the walk

    always_comb begin
        events_d                    = '0;
        events_d[EVT_CYCLE]         = 1'b1;
        events_d[EVT_IC_REQ]        = icache_req_valid_i;
        events_d[EVT_IC_KILL]       = icache_req_kill_i;
        events_d[EVT_IC_BUSY]       = !icache_ready_i;
        events_d[EVT_L2_HIT]        = l2_hit_evt;
        events_d[EVT_ITLB_MISS_CYC] = itlb_miss_cyc;
        events_d[EVT_LOAD]          = dmem_is_load_i;
        events_d[EVT_STORE]         = dmem_is_store_i;
    end

    // One register stage between the core and the counters
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            events_q <= '0;
        end else begin
            events_q <= events_d;
        end
    end

    assign events_o = events_q;

endmodule

//--- hpm/hpm_counter_bank.sv
// Performance monitor counter bank
// Per-counter event select, gated increment
// and preload from the register port

`timescale 1ns/1ps

module hpm_counter_bank
    import hpm_pkg::*;
#(
    parameter int unsigned NUM_COUNTERS = 4
) (
    input  logic                         CLK,
    input  logic                         RST,
    input  hpm_events_t                  events_i,  // Registered event lines
    input  logic                         enable_i,  // Global enable
    input  evt_sel_t  [NUM_COUNTERS-1:0] sel_i,
    input  cnt_wr_t                      cnt_wr_i,
    output hpm_data_t [NUM_COUNTERS-1:0] counts_o
);

    hpm_data_t [NUM_COUNTERS-1:0] cnt_q;
    hpm_data_t [NUM_COUNTERS-1:0] cnt_d;
    logic      [NUM_COUNTERS-1:0] evt_hit;
    logic      [NUM_COUNTERS-1:0] inc;
    logic      [NUM_COUNTERS-1:0] load;

    // ------------------------------
    // Event pick and strobes
    // ------------------------------
    always_comb begin
        for (int n = 0; n < NUM_COUNTERS; n++) begin
            evt_hit[n] = events_i[sel_i[n]];
            inc[n]     = enable_i && evt_hit[n];
            load[n]    = cnt_wr_i.valid && (cnt_wr_i.idx == cnt_idx_t'(n));
        end
    end

    // ------------------------------
    // Next value
    // ------------------------------
    always_comb begin
        for (int n = 0; n < NUM_COUNTERS; n++) begin
            if (load[n]) begin
                cnt_d[n] = cnt_wr_i.data;  // Preload wins over counting
            end else if (inc[n]) begin
                cnt_d[n] = cnt_q[n] + hpm_data_t'(1);  // Wraps at 2^32
            end else begin
                cnt_d[n] = cnt_q[n];
            end
        end
    end

    // Counter registers
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    assign counts_o = cnt_q;

endmodule

//--- hpm/hpm_apb_regs.sv
// Performance monitor APB register block
// Zero wait state APB slave with map decode
// Control and selector registers, counter preload strobe
// Read data mux and error response

`timescale 1ns/1ps

module hpm_apb_regs
    import hpm_pkg::*;
#(
    parameter int unsigned NUM_COUNTERS = 4
) (
    input  logic                         CLK,
    input  logic                         RST,
    input  apb_req_t                     apb_req_i,
    input  hpm_data_t [NUM_COUNTERS-1:0] counts_i,
    output apb_rsp_t                     apb_rsp_o,
    output logic                         enable_o,
    output evt_sel_t  [NUM_COUNTERS-1:0] sel_o,
    output cnt_wr_t                      cnt_wr_o
);

    // Selector window ends where the counter window starts
    localparam apb_addr_t SEL_END = REG_CNT_BASE;
    localparam apb_addr_t CNT_END = apb_addr_t'(REG_CNT_BASE + 4 * MAX_COUNTERS);

    logic                        access;
    logic                        aligned;
    logic                        ctrl_hit;
    logic                        sel_hit;
    logic                        cnt_hit;
    logic                        mapped;
    logic                        wr_en;
    apb_addr_t                   sel_offs;
    apb_addr_t                   cnt_offs;
    cnt_idx_t                    sel_idx;
    cnt_idx_t                    cnt_idx;
    hpm_data_t                   rdata;
    logic                        ctrl_en_q;
    evt_sel_t [NUM_COUNTERS-1:0] sel_q;

    // ------------------------------
    // Address decode
    // ------------------------------
    assign access   = apb_req_i.psel && apb_req_i.penable;  // Access phase
    assign aligned  = (apb_req_i.paddr[1:0] == 2'b00);
    assign sel_offs = apb_req_i.paddr - REG_SEL_BASE;
    assign cnt_offs = apb_req_i.paddr - REG_CNT_BASE;
    assign sel_idx  = sel_offs[CNT_IDX_W+1:2];
    assign cnt_idx  = cnt_offs[CNT_IDX_W+1:2];

    assign ctrl_hit = (apb_req_i.paddr == REG_CTRL);

    assign sel_hit = aligned
                     && (apb_req_i.paddr >= REG_SEL_BASE)
                     && (apb_req_i.paddr < SEL_END)
                     && (32'(sel_idx) < NUM_COUNTERS);

    assign cnt_hit = aligned
                     && (apb_req_i.paddr >= REG_CNT_BASE)
                     && (apb_req_i.paddr < CNT_END)
                     && (32'(cnt_idx) < NUM_COUNTERS);

    assign mapped = ctrl_hit || sel_hit || cnt_hit;
    assign wr_en  = access && apb_req_i.pwrite && mapped;

    // ------------------------------
    // Control and selectors
    // ------------------------------
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            ctrl_en_q <= 1'b0;
            sel_q     <= '0;
        end else if (wr_en) begin
            if (ctrl_hit) begin
                ctrl_en_q <= apb_req_i.pwdata[CTRL_EN_BIT];
            end
            if (sel_hit) begin
                sel_q[sel_idx] <= apb_req_i.pwdata[EVT_SEL_W-1:0];  // Low bits only
            end
        end
    end

    // Preload strobe taken by the counter bank at the access-ending edge
    always_comb begin
        cnt_wr_o.valid = wr_en && cnt_hit;
        cnt_wr_o.idx   = cnt_idx;
        cnt_wr_o.data  = apb_req_i.pwdata;
    end

    // ------------------------------
    // Read path
    // ------------------------------
    always_comb begin
        rdata = '0;  // Unmapped reads return zero
        if (ctrl_hit) begin
            rdata[CTRL_EN_BIT] = ctrl_en_q;
        end else if (sel_hit) begin
            rdata = hpm_data_t'(sel_q[sel_idx]);
        end else if (cnt_hit) begin
            rdata = counts_i[cnt_idx];
        end
    end

    always_comb begin
        apb_rsp_o.pready  = access;  // No wait states
        apb_rsp_o.pslverr = access && !mapped;
        apb_rsp_o.prdata  = (access && !apb_req_i.pwrite) ? rdata : '0;
    end

    assign enable_o = ctrl_en_q;
    assign sel_o    = sel_q;

endmodule

//--- hdl/hpm_top.sv
// Performance monitor top level
// Event conditioning, counter bank and APB register block

`timescale 1ns/1ps

module hpm_top
    import hpm_pkg::*;
#(
    parameter int unsigned NUM_COUNTERS = 4
) (
    input  logic       CLK,
    input  logic       RST,

    // Register port
    input  apb_req_t   apb_req_i,
    output apb_rsp_t   apb_rsp_o,

    // Raw core events
    input  logic       icache_req_valid_i,
    input  logic       icache_req_kill_i,
    input  logic       icache_ready_i,
    input  logic       grant_valid_i,
    input  logic [1:0] grant_beat_i,
    input  logic       l2_hit_i,
    input  logic       itlb_miss_i,
    input  logic       itlb_ready_i,
    input  logic       dmem_is_load_i,
    input  logic       dmem_is_store_i
);

    hpm_events_t                  events;
    logic                         enable;
    evt_sel_t  [NUM_COUNTERS-1:0] sel;
    cnt_wr_t                      cnt_wr;
    hpm_data_t [NUM_COUNTERS-1:0] counts;

    hpm_event_gen u_event_gen (
        .CLK                (CLK),
        .RST                (RST),
        .icache_req_valid_i (icache_req_valid_i),
        .icache_req_kill_i  (icache_req_kill_i),
        .icache_ready_i     (icache_ready_i),
        .grant_valid_i      (grant_valid_i),
        .grant_beat_i       (grant_beat_i),
        .l2_hit_i           (l2_hit_i),
        .itlb_miss_i        (itlb_miss_i),
        .itlb_ready_i       (itlb_ready_i),
        .dmem_is_load_i     (dmem_is_load_i),
        .dmem_is_store_i    (dmem_is_store_i),
        .events_o           (events)
    );

    hpm_counter_bank #(
        .NUM_COUNTERS (NUM_COUNTERS)
    ) u_counter_bank (
        .CLK      (CLK),
        .RST      (RST),
        .events_i (events),
        .enable_i (enable),
        .sel_i    (sel),
        .cnt_wr_i (cnt_wr),
        .counts_o (counts)
    );

    hpm_apb_regs #(
        .NUM_COUNTERS (NUM_COUNTERS)
    ) u_apb_regs (
        .CLK       (CLK),
        .RST       (RST),
        .apb_req_i (apb_req_i),
        .counts_i  (counts),
        .apb_rsp_o (apb_rsp_o),
        .enable_o  (enable),
        .sel_o     (sel),
        .cnt_wr_o  (cnt_wr)
    );

endmodule

//--- testbench/hpm_tb_tasks.svh
// Testbench helpers
// LCG, value compare, APB register accesses and idle cycles

`ifndef HPM_TB_TASKS_SVH
`define HPM_TB_TASKS_SVH

function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_cnt++;
    if (act !== exp) begin
        err_cnt++;
        test_err++;
        $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

// Keeps the caller 1 ns past a rising edge
task automatic wait_cycles(input int n);
    repeat (n) begin
        @(posedge CLK);
        #1;
    end
endtask

// Setup phase, then access phase, response sampled once settled
task automatic apb_access(input logic wr, input apb_addr_t addr, input hpm_data_t wdata,
                          output hpm_data_t rdata, output logic err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge CLK);
    #1;
    apb_req.penable = 1'b1;
    #10;
    compare_value("pready", 32'd1, 32'(apb_rsp.pready));
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge CLK);  // Write commits here
    #1;
    apb_req = '0;
endtask

task automatic write_reg(input apb_addr_t addr, input hpm_data_t data, output logic err);
    hpm_data_t unused;
    apb_access(1'b1, addr, data, unused, err);
endtask

task automatic read_reg(input apb_addr_t addr, output hpm_data_t data, output logic err);
    apb_access(1'b0, addr, '0, data, err);
endtask

`endif

//--- testbench/tb_hpm_top.sv
// Testbench for the performance monitor top level
// Clock, reset, stimulus table applied in a loop, watchdog and summary

`timescale 1ns/1ps

module tb_hpm_top
    import hpm_pkg::*;
();

    localparam int NUM_CNT      = 4;
    localparam int NUM_ROWS     = 7;
    localparam int ROW_OVERHEAD = 80;  // Cycles of APB traffic around each window
    localparam int RESET_CYCLES = 16;
    localparam int CLK_HALF     = 50;

    typedef struct packed {
        logic [10:0]  raw_val;   // Named raw inputs
        logic [10:0]  raw_mask;  // 1 where the row names the input
        logic [31:0]  sel;       // One selector byte per counter
        logic [127:0] pre;       // One preload word per counter
        logic [3:0]   rand_pre;  // Counters preloaded from the LCG
        logic [15:0]  cycles;    // Enable window length or zero for none
    } row_t;

    logic        CLK;
    logic        RST;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [10:0] raw_in;  // req, kill, ic_ready, gnt, beat[1:0], l2_hit, miss, tlb_rdy, ld, st
    row_t        rows [NUM_ROWS];
    string       row_name [NUM_ROWS];
    logic [31:0] lcg_state;
    logic        rows_ready;
    int          edge_cnt;
    int          check_cnt;
    int          err_cnt;
    int          test_err;
    int          test_cnt;
    hpm_data_t   exp_cnt [NUM_CNT];
    logic [2:0]  exp_sel [NUM_CNT];
    logic        exp_ctrl;

    `include "hpm_tb_tasks.svh"

    hpm_top #(
        .NUM_COUNTERS (NUM_CNT)
    ) dut_i (
        .CLK                (CLK),
        .RST                (RST),
        .apb_req_i          (apb_req),
        .apb_rsp_o          (apb_rsp),
        .icache_req_valid_i (raw_in[10]),
        .icache_req_kill_i  (raw_in[9]),
        .icache_ready_i     (raw_in[8]),
        .grant_valid_i      (raw_in[7]),
        .grant_beat_i       (raw_in[6:5]),
        .l2_hit_i           (raw_in[4]),
        .itlb_miss_i        (raw_in[3]),
        .itlb_ready_i       (raw_in[2]),
        .dmem_is_load_i     (raw_in[1]),
        .dmem_is_store_i    (raw_in[0])
    );

    always #CLK_HALF CLK = ~CLK;

    always @(posedge CLK) edge_cnt <= edge_cnt + 1;  // Edge counter for enable windows

    function automatic row_t make_row(input logic [10:0] rv, input logic [10:0] rm,
                                      input logic [31:0] sel, input logic [127:0] pre,
                                      input logic [3:0] rp, input logic [15:0] cyc);
        row_t row;
        row.raw_val  = rv;
        row.raw_mask = rm;
        row.sel      = sel;
        row.pre      = pre;
        row.rand_pre = rp;
        row.cycles   = cyc;
        return row;
    endfunction

    // Event a counter should see for the given raw inputs
    function automatic logic event_expected(input logic [10:0] raw, input logic [2:0] sel);
        case (sel)
            3'd0:    return 1'b1;
            3'd1:    return raw[10];
            3'd2:    return raw[9];
            3'd3:    return !raw[8];
            3'd4:    return raw[7] && (raw[6:5] == 2'd3) && raw[4];  // Last beat only
            3'd5:    return raw[3] && !raw[2];
            3'd6:    return raw[1];
            default: return raw[0];
        endcase
    endfunction

    task automatic verify_read(input string name, input apb_addr_t addr, input hpm_data_t exp);
        hpm_data_t data;
        logic      err;
        read_reg(addr, data, err);
        compare_value(name, exp, data);
        compare_value({name, " pslverr"}, 32'd0, 32'(err));
    endtask

    task automatic checked_write(input apb_addr_t addr, input hpm_data_t data);
        logic err;
        write_reg(addr, data, err);
        compare_value("pslverr", 32'd0, 32'(err));
    endtask

    task automatic verify_all_regs();
        verify_read("ctrl", REG_CTRL, hpm_data_t'(exp_ctrl));
        for (int n = 0; n < NUM_CNT; n++) begin
            verify_read($sformatf("sel%0d", n), REG_SEL_BASE + 8'(4 * n), 32'(exp_sel[n]));
            verify_read($sformatf("cnt%0d", n), REG_CNT_BASE + 8'(4 * n), exp_cnt[n]);
        end
    endtask

    task automatic report_test(input string name);
        test_cnt++;
        $display("Test %-12s %s, %0d errors", name, (test_err == 0) ? "ok" : "FAILED", test_err);
        test_err = 0;
    endtask

    // ------------------------------
    // One table row
    // ------------------------------
    task automatic run_row(input int r);
        row_t      row;
        hpm_data_t pre;
        int        k;
        int        m;
        row = rows[r];
        lcg_state = next_random(lcg_state);
        raw_in = (row.raw_val & row.raw_mask) | (lcg_state[26:16] & ~row.raw_mask);
        wait_cycles(2);
        for (int n = 0; n < NUM_CNT; n++) begin
            checked_write(REG_SEL_BASE + 8'(4 * n), hpm_data_t'(row.sel[n*8 +: 8]));
            exp_sel[n] = row.sel[n*8 +: 3];
        end
        for (int n = 0; n < NUM_CNT; n++) begin
            lcg_state = next_random(lcg_state);
            pre = row.rand_pre[n] ? lcg_state : row.pre[n*32 +: 32];
            checked_write(REG_CNT_BASE + 8'(4 * n), pre);
            exp_cnt[n] = pre;
        end
        wait_cycles(4);  // Idle with counting off
        verify_all_regs();
        if (row.cycles != 0) begin
            checked_write(REG_CTRL, 32'd1);
            k = edge_cnt;
            exp_ctrl = 1'b1;
            verify_read("ctrl", REG_CTRL, 32'd1);
            while (edge_cnt - k < int'(row.cycles) - 2) begin
                wait_cycles(1);
            end
            checked_write(REG_CTRL, 32'd0);
            m = edge_cnt;
            exp_ctrl = 1'b0;
            for (int n = 0; n < NUM_CNT; n++) begin
                if (event_expected(raw_in, exp_sel[n])) begin
                    exp_cnt[n] = exp_cnt[n] + hpm_data_t'(m - k);
                end
            end
            wait_cycles(5);  // Counters hold once disabled
            verify_all_regs();
        end
        report_test(row_name[r]);
    endtask

    task automatic run_unmapped();
        apb_addr_t bad [5];
        hpm_data_t data;
        logic      err;
        bad[0] = 8'h30;
        bad[1] = 8'h12;  // Misaligned
        bad[2] = 8'h34;  // Counter slot 5
        bad[3] = 8'h04;
        bad[4] = 8'h01;
        for (int i = 0; i < 5; i++) begin
            write_reg(bad[i], 32'hFFFF_FFFF, err);
            compare_value($sformatf("pslverr wr %h", bad[i]), 32'd1, 32'(err));
            read_reg(bad[i], data, err);
            compare_value($sformatf("pslverr rd %h", bad[i]), 32'd1, 32'(err));
            compare_value($sformatf("prdata %h", bad[i]), 32'd0, data);
        end
        wait_cycles(3);
        verify_all_regs();
        report_test("unmapped");
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        CLK        = 1'b0;
        RST        = 1'b0;
        apb_req    = '0;
        raw_in     = '0;
        lcg_state  = 32'hb9db89e2;
        edge_cnt   = 0;
        check_cnt  = 0;
        err_cnt    = 0;
        test_err   = 0;
        test_cnt   = 0;
        exp_ctrl   = 1'b0;
        for (int n = 0; n < NUM_CNT; n++) begin
            exp_cnt[n] = '0;
            exp_sel[n] = '0;
        end
        rows[0] = make_row(11'h000, 11'h000, 32'hFE0BF9F8,
                           {32'h89AB_CDEF, 32'hFFFF_FFFF, 32'h0000_0001, 32'h1234_5678},
                           4'b0000, 16'd0);
        rows[1] = make_row(11'h000, 11'h000, 32'h0000_0000,
                           {32'd0, 32'd0, 32'h0000_0100, 32'd0}, 4'b0001, 16'd24);
        rows[2] = make_row(11'h0F8, 11'h1FC, 32'h0005_0403, 128'd0, 4'b0000, 16'd16);
        rows[3] = make_row(11'h1DC, 11'h1FC, 32'h0005_0403, 128'd0, 4'b0000, 16'd16);
        rows[4] = make_row(11'h070, 11'h1FC, 32'h0405_0403, 128'd0, 4'b0000, 16'd12);
        // Last beat granted without the L2 hit flag
        rows[5] = make_row(11'h0E0, 11'h1FC, 32'h0005_0403, 128'd0, 4'b0000, 16'd12);
        rows[6] = make_row(11'h403, 11'h603, 32'h0706_0201,
                           {32'hFFFF_FFF8, 32'h0000_0010, 32'h0000_0005, 32'd0},
                           4'b0000, 16'd20);
        row_name[0] = "round_trip";
        row_name[1] = "cycles";
        row_name[2] = "derived_hit";
        row_name[3] = "derived_miss";
        row_name[4] = "derived_idle";
        row_name[5] = "derived_nohit";
        row_name[6] = "parallel";
        rows_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        RST = 1'b1;
        compare_value("idle pready", 32'd0, 32'(apb_rsp.pready));
        compare_value("idle pslverr", 32'd0, 32'(apb_rsp.pslverr));
        verify_all_regs();
        report_test("reset");
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        run_unmapped();

        $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog sized from the table, with reset and unmapped tests as two more rows
    initial begin
        longint limit_ns;
        int     max_cyc;
        wait (rows_ready === 1'b1);
        max_cyc = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (int'(rows[r].cycles) > max_cyc) begin
                max_cyc = int'(rows[r].cycles);
            end
        end
        limit_ns = longint'(NUM_ROWS + 2) * (max_cyc + ROW_OVERHEAD) * 2 * CLK_HALF
                   + RESET_CYCLES * 2 * CLK_HALF;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+testbench
common/hpm_pkg.sv
hpm/hpm_event_gen.sv
hpm/hpm_counter_bank.sv
hpm/hpm_apb_regs.sv
hdl/hpm_top.sv
testbench/tb_hpm_top.sv
